// ==== logic/opn_regmap_pkg.sv ====
package opn_regmap_pkg;

    // Bank 0 register addresses
    localparam logic [7:0] REG_TIMER_A_HI = 8'h24;  // Timer A bits 9..2
    localparam logic [7:0] REG_TIMER_A_LO = 8'h25;  // Timer A bits 1..0
    localparam logic [7:0] REG_TIMER_B    = 8'h26;
    localparam logic [7:0] REG_TIMER_CTL  = 8'h27;
    localparam logic [7:0] REG_DAC_DATA   = 8'h2A;
    localparam logic [7:0] REG_DAC_EN     = 8'h2B;
    localparam logic [7:0] REG_PAN_CH6    = 8'hB6;  // Channel 6 carries the DAC

    // Timer control register 0x27
    localparam logic [2:0] CTL_LOAD_A = 3'd0;
    localparam logic [2:0] CTL_LOAD_B = 3'd1;
    localparam logic [2:0] CTL_EN_A   = 3'd2;
    localparam logic [2:0] CTL_EN_B   = 3'd3;
    localparam logic [2:0] CTL_RST_A  = 3'd4;
    localparam logic [2:0] CTL_RST_B  = 3'd5;

    // DAC enable register 0x2B
    localparam logic [2:0] DAC_EN_BIT = 3'd7;

    // Pan register, left is the upper bit
    localparam logic [2:0] PAN_LEFT_BIT  = 3'd7;
    localparam logic [2:0] PAN_RIGHT_BIT = 3'd6;

    // Sample bytes are offset binary
    localparam logic [7:0] DAC_OFFSET = 8'd128;

endpackage

// ==== logic/opn_timing_pkg.sv ====
package opn_timing_pkg;

    // Timer counter widths
    localparam logic [3:0] TIMER_A_W = 4'd10;
    localparam logic [3:0] TIMER_B_W = 4'd8;

    // Timer B advances once every 16 sample frames
    localparam logic [4:0] TIMER_B_PRESCALE = 5'd16;

    localparam logic [2:0] OPS_PER_CH = 3'd4;   // Operator slots per channel

    // Busy flag length in clk_en pulses
    localparam logic [5:0] BUSY_TICKS = 6'd32;

    // Output sample format
    localparam logic [4:0] SND_W     = 5'd16;
    localparam logic [2:0] DAC_SHIFT = 3'd6;   // Gain applied to the 8-bit DAC value

    // Defaults for the top level parameters
    localparam logic [3:0] DEF_CLK_DIV = 4'd6;
    localparam logic [3:0] DEF_NUM_CH  = 4'd6;

endpackage

// ==== logic/opn_clock_gen.sv ====
`timescale 1ns/10ps

module opn_clock_gen import opn_timing_pkg::*; #(
    parameter int clk_div = DEF_CLK_DIV,   // cen pulses per clk_en
    parameter int num_ch  = DEF_NUM_CH
) (
    input  logic clk,
    input  logic rst,
    input  logic cen,
    output logic clk_en,
    output logic zero
);

    localparam int SLOTS  = num_ch * OPS_PER_CH;   // Operator slots in one frame
    localparam int DIV_W  = $clog2(clk_div + 1);
    localparam int SLOT_W = $clog2(SLOTS);

    logic [DIV_W-1:0]  div_cnt;
    logic [SLOT_W-1:0] slot_cnt;

    always_ff @(posedge clk) begin
        if (rst) begin
            div_cnt  <= '0;
            slot_cnt <= '0;
            clk_en   <= 1'b0;
            zero     <= 1'b0;
        end else begin
            clk_en <= 1'b0;
            zero   <= 1'b0;
            if (cen) begin
                if (div_cnt == DIV_W'(clk_div - 1)) begin
                    div_cnt <= '0;
                    clk_en  <= 1'b1;
                    // Frame marker rides on the last slot's clk_en
                    if (slot_cnt == SLOT_W'(SLOTS - 1)) begin
                        slot_cnt <= '0;
                        zero     <= 1'b1;
                    end else begin
                        slot_cnt <= slot_cnt + 1'b1;
                    end
                end else begin
                    div_cnt <= div_cnt + 1'b1;
                end
            end
        end
    end

endmodule

// ==== logic/opn_reg_bus.sv ====
`timescale 1ns/10ps

module opn_reg_bus import opn_timing_pkg::*, opn_regmap_pkg::*; (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 clk_en,
    input  logic                 cs_n,
    input  logic                 wr_n,
    input  logic [1:0]           addr,
    input  logic [7:0]           din,
    output logic                 busy,
    // Timer registers
    output logic [TIMER_A_W-1:0] value_a,
    output logic [TIMER_B_W-1:0] value_b,
    output logic                 load_a,
    output logic                 load_b,
    output logic                 en_a,
    output logic                 en_b,
    output logic                 clr_a,
    output logic                 clr_b,
    // DAC registers
    output logic [7:0]           dac_data,
    output logic                 dac_en,
    output logic                 pan_left,
    output logic                 pan_right
);

    logic                          write;
    logic                          addr_wr;
    logic                          data_wr;
    logic                          bank0_wr;
    logic [7:0]                    reg_sel;    // Latched register address
    logic                          reg_bank;   // Bank of the latched address
    logic [$bits(BUSY_TICKS)-1:0]  busy_cnt;

    assign write    = !cs_n && !wr_n;
    assign addr_wr  = write && !addr[0];
    assign data_wr  = write && addr[0];
    assign bank0_wr = data_wr && !addr[1] && !reg_bank;   // Bank 1 is dropped

    always_ff @(posedge clk) begin
        if (rst) begin
            reg_sel  <= '0;
            reg_bank <= 1'b0;
        end else if (addr_wr) begin
            reg_sel  <= din;
            reg_bank <= addr[1];
        end
    end

    // Control fields
    always_ff @(posedge clk) begin
        if (rst) begin
            value_a   <= '0;
            value_b   <= '0;
            load_a    <= 1'b0;
            load_b    <= 1'b0;
            en_a      <= 1'b0;
            en_b      <= 1'b0;
            clr_a     <= 1'b0;
            clr_b     <= 1'b0;
            dac_en    <= 1'b0;
            pan_left  <= 1'b1;   // Both sides on out of reset
            pan_right <= 1'b1;
        end else begin
            clr_a <= 1'b0;
            clr_b <= 1'b0;
            if (bank0_wr) begin
                case (reg_sel)
                    REG_TIMER_A_HI: value_a[TIMER_A_W-1:2] <= din;
                    REG_TIMER_A_LO: value_a[1:0]           <= din[1:0];
                    REG_TIMER_B:    value_b                <= din;
                    REG_TIMER_CTL: begin
                        load_a <= din[CTL_LOAD_A];
                        load_b <= din[CTL_LOAD_B];
                        en_a   <= din[CTL_EN_A];
                        en_b   <= din[CTL_EN_B];
                        clr_a  <= din[CTL_RST_A];   // Pulse only
                        clr_b  <= din[CTL_RST_B];
                    end
                    REG_DAC_EN: dac_en <= din[DAC_EN_BIT];
                    REG_PAN_CH6: begin
                        pan_left  <= din[PAN_LEFT_BIT];
                        pan_right <= din[PAN_RIGHT_BIT];
                    end
                    default: ;
                endcase
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst)
            dac_data <= '0;
        else if (bank0_wr && reg_sel == REG_DAC_DATA)
            dac_data <= din;
    end

    // Busy runs for BUSY_TICKS clk_en pulses after any data write
    always_ff @(posedge clk) begin
        if (rst) begin
            busy     <= 1'b0;
            busy_cnt <= '0;
        end else if (data_wr) begin
            busy     <= 1'b1;
            busy_cnt <= BUSY_TICKS;   // Restarts if already busy
        end else if (busy && clk_en) begin
            busy_cnt <= busy_cnt - 1'b1;
            if (busy_cnt == 1)
                busy <= 1'b0;
        end
    end

endmodule

// ==== logic/opn_timers.sv ====
`timescale 1ns/10ps

module opn_timers import opn_timing_pkg::*; (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 zero,      // Frame strobe, aligned with clk_en
    input  logic [TIMER_A_W-1:0] value_a,
    input  logic [TIMER_B_W-1:0] value_b,
    input  logic                 load_a,
    input  logic                 load_b,
    input  logic                 en_a,
    input  logic                 en_b,
    input  logic                 clr_a,
    input  logic                 clr_b,
    output logic                 flag_a,
    output logic                 flag_b,
    output logic                 irq_n
);

    localparam int PRE_W = $clog2(TIMER_B_PRESCALE);

    logic [TIMER_A_W-1:0] cnt_a;
    logic [TIMER_B_W-1:0] cnt_b;
    logic [PRE_W-1:0]     pre_b;
    logic                 step_b;
    logic                 ovf_a;
    logic                 ovf_b;

    assign step_b = zero && pre_b == PRE_W'(TIMER_B_PRESCALE - 1);
    assign ovf_a  = load_a && zero && &cnt_a;
    assign ovf_b  = load_b && step_b && &cnt_b;

    // Timer A counts frames
    always_ff @(posedge clk) begin
        if (rst) begin
            cnt_a <= '0;
        end else if (!load_a) begin
            cnt_a <= value_a;   // Stopped, preset for the next load
        end else if (zero) begin
            if (ovf_a)
                cnt_a <= value_a;
            else
                cnt_a <= cnt_a + 1'b1;
        end
    end

    // Timer B counts groups of TIMER_B_PRESCALE frames
    always_ff @(posedge clk) begin
        if (rst) begin
            cnt_b <= '0;
            pre_b <= '0;
        end else if (!load_b) begin
            cnt_b <= value_b;
            pre_b <= '0;
        end else if (zero) begin
            pre_b <= pre_b + 1'b1;   // Wraps at the prescale count
            if (step_b) begin
                if (ovf_b)
                    cnt_b <= value_b;
                else
                    cnt_b <= cnt_b + 1'b1;
            end
        end
    end

    // A fresh overflow beats a clear in the same cycle
    always_ff @(posedge clk) begin
        if (rst) begin
            flag_a <= 1'b0;
            flag_b <= 1'b0;
        end else begin
            if (ovf_a && en_a)
                flag_a <= 1'b1;
            else if (clr_a)
                flag_a <= 1'b0;
            if (ovf_b && en_b)
                flag_b <= 1'b1;
            else if (clr_b)
                flag_b <= 1'b0;
        end
    end

    assign irq_n = !(flag_a || flag_b);

endmodule

// ==== logic/opn_dac.sv ====
`timescale 1ns/10ps

module opn_dac import opn_timing_pkg::*, opn_regmap_pkg::*; (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    zero,
    input  logic [7:0]              dac_data,
    input  logic                    dac_en,
    input  logic                    pan_left,
    input  logic                    pan_right,
    output logic signed [SND_W-1:0] snd_left,
    output logic signed [SND_W-1:0] snd_right
);

    logic signed [8:0]       pcm;       // Centered sample, -128..127
    logic signed [SND_W-1:0] pcm_snd;

    assign pcm     = $signed({1'b0, dac_data}) - $signed({1'b0, DAC_OFFSET});
    assign pcm_snd = {{(SND_W - 9){pcm[8]}}, pcm} <<< DAC_SHIFT;

    // New sample once per frame
    always_ff @(posedge clk) begin
        if (rst) begin
            snd_left  <= '0;
            snd_right <= '0;
        end else if (zero) begin
            snd_left  <= (dac_en && pan_left)  ? pcm_snd : '0;
            snd_right <= (dac_en && pan_right) ? pcm_snd : '0;
        end
    end

endmodule

// ==== logic/opn_top.sv ====
`timescale 1ns/10ps

module opn_top import opn_timing_pkg::*; #(
    parameter int clk_div = DEF_CLK_DIV,
    parameter int num_ch  = DEF_NUM_CH     // 3 or 6
) (
    input  logic                    rst,
    input  logic                    clk,
    input  logic                    cen,        // Tie high if unused
    input  logic                    cs_n,
    input  logic                    wr_n,
    input  logic [1:0]              addr,
    input  logic [7:0]              din,
    output logic [7:0]              dout,
    output logic                    irq_n,
    output logic                    snd_sample,
    output logic signed [SND_W-1:0] snd_left,
    output logic signed [SND_W-1:0] snd_right
);

    logic                 clk_en;
    logic                 zero;
    logic                 busy;
    logic                 flag_a, flag_b;
    logic [TIMER_A_W-1:0] value_a;
    logic [TIMER_B_W-1:0] value_b;
    logic                 load_a, load_b;
    logic                 en_a, en_b;
    logic                 clr_a, clr_b;
    logic [7:0]           dac_data;
    logic                 dac_en, pan_left, pan_right;

    opn_clock_gen #(.clk_div(clk_div), .num_ch(num_ch)) u_clock_gen (
        .clk    ( clk    ),
        .rst    ( rst    ),
        .cen    ( cen    ),
        .clk_en ( clk_en ),
        .zero   ( zero   )
    );

    opn_reg_bus u_reg_bus (
        .clk       ( clk       ),
        .rst       ( rst       ),
        .clk_en    ( clk_en    ),
        .cs_n      ( cs_n      ),
        .wr_n      ( wr_n      ),
        .addr      ( addr      ),
        .din       ( din       ),
        .busy      ( busy      ),
        .value_a   ( value_a   ),
        .value_b   ( value_b   ),
        .load_a    ( load_a    ),
        .load_b    ( load_b    ),
        .en_a      ( en_a      ),
        .en_b      ( en_b      ),
        .clr_a     ( clr_a     ),
        .clr_b     ( clr_b     ),
        .dac_data  ( dac_data  ),
        .dac_en    ( dac_en    ),
        .pan_left  ( pan_left  ),
        .pan_right ( pan_right )
    );

    opn_timers u_timers (
        .clk     ( clk     ),
        .rst     ( rst     ),
        .zero    ( zero    ),
        .value_a ( value_a ),
        .value_b ( value_b ),
        .load_a  ( load_a  ),
        .load_b  ( load_b  ),
        .en_a    ( en_a    ),
        .en_b    ( en_b    ),
        .clr_a   ( clr_a   ),
        .clr_b   ( clr_b   ),
        .flag_a  ( flag_a  ),
        .flag_b  ( flag_b  ),
        .irq_n   ( irq_n   )
    );

    opn_dac u_dac (
        .clk       ( clk       ),
        .rst       ( rst       ),
        .zero      ( zero      ),
        .dac_data  ( dac_data  ),
        .dac_en    ( dac_en    ),
        .pan_left  ( pan_left  ),
        .pan_right ( pan_right ),
        .snd_left  ( snd_left  ),
        .snd_right ( snd_right )
    );

    // Status byte reads the same at every address
    assign dout       = {busy, 5'd0, flag_b, flag_a};
    assign snd_sample = zero;

endmodule

// ==== tests/opn_tb_ref.svh ====
`ifndef OPN_TB_REF_SVH
`define OPN_TB_REF_SVH

// Expected DAC output on one side of the stereo pair
function automatic logic signed [SND_W-1:0] ref_dac_out(input logic [7:0] data,
                                                       input logic en,
                                                       input logic side_on);
    int centered;
    if (!en || !side_on)
        return '0;
    centered = int'(data) - int'(DAC_OFFSET);   // Offset binary to two's complement
    return SND_W'(centered * (2 ** DAC_SHIFT));
endfunction

// Frames from load to overflow of timer A
function automatic int timer_a_frames(input int value);
    return (2 ** TIMER_A_W) - value;
endfunction

// Timer B only steps once per prescaler wrap
function automatic int timer_b_frames(input int value);
    return ((2 ** TIMER_B_W) - value) * TIMER_B_PRESCALE;
endfunction

// 16-bit Galois LFSR, taps 16 14 13 11
function automatic logic [15:0] lfsr_next(input logic [15:0] state);
    if (state[0])
        return (state >> 1) ^ 16'hB400;
    else
        return state >> 1;
endfunction

`endif

// ==== tests/opn_tb.sv ====
`timescale 1ns/10ps

module opn_tb import opn_timing_pkg::*, opn_regmap_pkg::*; ();

    `include "opn_tb_ref.svh"

    localparam int CLK_DIV      = 2;
    localparam int NUM_CH       = 3;
    localparam int FRAME_CLK    = CLK_DIV * NUM_CH * OPS_PER_CH;   // 24 clk per frame
    localparam int BUSY_MAX     = (BUSY_TICKS + 2) * CLK_DIV;
    localparam int DAC_WRITES   = 200;
    localparam int TIMER_A_LOAD = 1020;
    localparam int TIMER_B_LOAD = 255;

    logic                    clk;
    logic                    rst;
    logic                    cs_n;
    logic                    wr_n;
    logic [1:0]              addr;
    logic [7:0]              din;
    logic [7:0]              dout;
    logic                    irq_n;
    logic                    snd_sample;
    logic signed [SND_W-1:0] snd_left;
    logic signed [SND_W-1:0] snd_right;

    // Shadow copy of the DAC registers
    logic [7:0]              model_data;
    logic                    model_en;
    logic                    model_left;
    logic                    model_right;
    logic signed [SND_W-1:0] exp_left;
    logic signed [SND_W-1:0] exp_right;
    logic signed [SND_W-1:0] hold_left;    // Expected values captured at snd_sample
    logic signed [SND_W-1:0] hold_right;
    logic                    check_due;
    logic [15:0]             lfsr;
    int                      frame_cnt;
    int                      write_frame;
    int                      since_write;  // snd_sample pulses since the last data write
    int                      strobe_gap;   // Clock edges since the last snd_sample
    int                      dac_checks;

    opn_top #(.clk_div(CLK_DIV), .num_ch(NUM_CH)) u_opn_top (
        .rst        ( rst        ),
        .clk        ( clk        ),
        .cen        ( 1'b1       ),
        .cs_n       ( cs_n       ),
        .wr_n       ( wr_n       ),
        .addr       ( addr       ),
        .din        ( din        ),
        .dout       ( dout       ),
        .irq_n      ( irq_n      ),
        .snd_sample ( snd_sample ),
        .snd_left   ( snd_left   ),
        .snd_right  ( snd_right  )
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("TEST FAILED");
        $fatal(1, "Simulation stopped at the first error");
    endtask

    task automatic check_snd(input string name, input logic signed [SND_W-1:0] got,
                             input logic signed [SND_W-1:0] want);
        if (got !== want)
            abort_run($sformatf("CHECK FAILED: %s = 0x%h, expected 0x%h", name, got, want));
    endtask

    task automatic check_status(input string name, input logic [7:0] got,
                                input logic [7:0] want);
        if (got !== want)
            abort_run($sformatf("CHECK FAILED: %s = 0x%h, expected 0x%h", name, got, want));
    endtask

    task automatic check_irq(input string name, input logic got, input logic want);
        if (got !== want)
            abort_run($sformatf("CHECK FAILED: %s = 0x%h, expected 0x%h", name, got, want));
    endtask

    task automatic check_strobe(input string name, input logic got, input logic want);
        if (got !== want)
            abort_run($sformatf("CHECK FAILED: %s = 0x%h, expected 0x%h", name, got, want));
    endtask

    // LFSR output is its low bit
    task automatic draw_random_bits(input int count, output logic [7:0] bits);
        bits = '0;
        for (int i = 0; i < count; i++) begin
            bits = {bits[6:0], lfsr[0]};
            lfsr = lfsr_next(lfsr);
        end
    endtask

    // Updates the register shadow in the same cycle as the DUT sees the write
    task automatic track_write(input logic [7:0] reg_addr, input logic [7:0] value);
        write_frame = frame_cnt;
        since_write = 0;
        case (reg_addr)
            REG_DAC_DATA: model_data = value;
            REG_DAC_EN:   model_en   = value[DAC_EN_BIT];
            REG_PAN_CH6: begin
                model_left  = value[PAN_LEFT_BIT];
                model_right = value[PAN_RIGHT_BIT];
            end
            default: ;
        endcase
        exp_left  = ref_dac_out(model_data, model_en, model_left);
        exp_right = ref_dac_out(model_data, model_en, model_right);
    endtask

    task automatic write_reg(input logic [7:0] reg_addr, input logic [7:0] value);
        int waited;
        @(negedge clk);
        cs_n = 1'b0;
        wr_n = 1'b0;
        addr = 2'b00;
        din  = reg_addr;
        @(negedge clk);
        addr = 2'b01;
        din  = value;
        track_write(reg_addr, value);
        @(negedge clk);
        cs_n = 1'b1;
        wr_n = 1'b1;
        check_status("dout busy bit", dout & 8'h80, 8'h80);
        waited = 0;
        while (dout[7] && waited < BUSY_MAX) begin
            @(negedge clk);
            waited++;
        end
        if (dout[7])
            abort_run("The busy flag stayed high past its limit");
    endtask

    task automatic fire_timer(input string which, input int period, input logic [7:0] ctl,
                              input logic [7:0] status);
        int waited;
        int frames;
        write_reg(REG_TIMER_CTL, ctl);
        waited = 0;
        while (!(|(dout & status)) && waited < (period + 2) * FRAME_CLK) begin
            @(negedge clk);
            waited++;
        end
        if (!(|(dout & status)))
            abort_run($sformatf("Timer %s never set its flag", which));
        frames = frame_cnt - write_frame;
        if (frames < period - 1 || frames > period + 1)
            abort_run($sformatf("Timer %s fired after %0d frames instead of %0d",
                                which, frames, period));
        check_irq("irq_n", irq_n, 1'b0);
        check_status("dout", dout, status);
    endtask

    task automatic check_quiet(input int frames);
        int waited;
        waited = 0;
        while (waited < frames * FRAME_CLK) begin
            @(negedge clk);
            check_irq("irq_n", irq_n, 1'b1);
            waited++;
        end
    endtask

    task automatic wait_samples(input int count);
        int seen;
        int waited;
        seen   = 0;
        waited = 0;
        while (seen < count && waited < (count + 1) * FRAME_CLK) begin
            @(negedge clk);
            if (snd_sample)
                seen++;
            waited++;
        end
        if (seen < count)
            abort_run("The snd_sample pulses stopped arriving");
    endtask

    // Frame strobe spacing, frame counter and DAC output checks
    always @(posedge clk) begin
        if (!rst) begin
            if (strobe_gap >= 0)   // One pulse per FRAME_CLK once the first frame is seen
                check_strobe("snd_sample", snd_sample, strobe_gap == FRAME_CLK - 1);
            if (snd_sample)
                strobe_gap = 0;
            else if (strobe_gap >= 0)
                strobe_gap = strobe_gap + 1;
            if (check_due) begin   // Outputs were updated on the previous edge
                check_snd("snd_left", snd_left, hold_left);
                check_snd("snd_right", snd_right, hold_right);
                dac_checks = dac_checks + 1;
            end
            check_due = 1'b0;
            if (snd_sample) begin
                frame_cnt   = frame_cnt + 1;
                since_write = since_write + 1;
                if (since_write >= 2) begin
                    check_due  = 1'b1;
                    hold_left  = exp_left;
                    hold_right = exp_right;
                end
            end
        end
    end

    initial begin
        logic [7:0] sample;
        logic [7:0] pan;
        int         start_checks;
        rst         = 1'b1;
        cs_n        = 1'b1;
        wr_n        = 1'b1;
        addr        = 2'b00;
        din         = 8'h00;
        lfsr        = 16'd55;
        model_data  = 8'h00;
        model_en    = 1'b0;
        model_left  = 1'b1;   // Pan resets to both sides
        model_right = 1'b1;
        exp_left    = '0;
        exp_right   = '0;
        hold_left   = '0;
        hold_right  = '0;
        check_due   = 1'b0;
        frame_cnt   = 0;
        write_frame = 0;
        since_write = 0;
        strobe_gap  = -1;     // No frame seen yet
        dac_checks  = 0;
        repeat (2) @(negedge clk);
        rst = 1'b0;
        @(negedge clk);
        check_status("dout", dout, 8'h00);
        check_irq("irq_n", irq_n, 1'b1);

        // Timer A
        write_reg(REG_TIMER_A_HI, 8'(TIMER_A_LOAD >> 2));
        write_reg(REG_TIMER_A_LO, 8'(TIMER_A_LOAD & 3));
        fire_timer("A", timer_a_frames(TIMER_A_LOAD),
                   8'((1 << CTL_LOAD_A) | (1 << CTL_EN_A)), 8'h01);
        write_reg(REG_TIMER_CTL, 8'(1 << CTL_RST_A));
        check_irq("irq_n", irq_n, 1'b1);
        check_status("dout", dout, 8'h00);

        // Timer B
        write_reg(REG_TIMER_B, 8'(TIMER_B_LOAD));
        fire_timer("B", timer_b_frames(TIMER_B_LOAD),
                   8'((1 << CTL_LOAD_B) | (1 << CTL_EN_B)), 8'h02);
        write_reg(REG_TIMER_CTL, 8'(1 << CTL_RST_B));
        check_irq("irq_n", irq_n, 1'b1);
        check_status("dout", dout, 8'h00);

        // Both running with flags masked
        write_reg(REG_TIMER_CTL, 8'((1 << CTL_LOAD_A) | (1 << CTL_LOAD_B)));
        check_quiet(2 * timer_b_frames(TIMER_B_LOAD));
        write_reg(REG_TIMER_CTL, 8'h00);
        check_status("dout", dout, 8'h00);

        // Midpoint sample loaded before the DAC is enabled
        write_reg(REG_DAC_DATA, 8'h80);
        write_reg(REG_DAC_EN, 8'(1 << DAC_EN_BIT));
        start_checks = dac_checks;
        for (int i = 0; i < DAC_WRITES; i++) begin
            draw_random_bits(8, sample);
            draw_random_bits(2, pan);
            write_reg(REG_PAN_CH6, {pan[1:0], 6'd0});
            write_reg(REG_DAC_DATA, sample);
        end
        write_reg(REG_DAC_EN, 8'h00);   // Outputs go to 0
        wait_samples(3);

        if (dac_checks - start_checks < 2 * DAC_WRITES) begin
            abort_run("Fewer DAC samples were compared than writes were made");
        end else begin
            $display("TEST PASSED");
            $finish;
        end
    end

endmodule

// ==== verilog.f ====
+incdir+tests
logic/opn_regmap_pkg.sv
logic/opn_timing_pkg.sv
logic/opn_clock_gen.sv
logic/opn_reg_bus.sv
logic/opn_timers.sv
logic/opn_dac.sv
logic/opn_top.sv
tests/opn_tb.sv
